//--- Makefile
# Verilator build of the scene loader testbench
# run from the project root so the .mem path resolves

TOP := rtx_scene_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 \
		--top-module $(TOP) \
		-f files.f \
		-o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- files.f
logic/rtx_scene_pkg.sv
logic/uart_memflash.sv
logic/scene_buffer.sv
logic/scene_config_regs.sv
logic/frame_overwrite_latch.sv
logic/rtx_scene_top.sv
tests/rtx_scene_properties.sv
tests/rtx_scene_tb.sv

//--- logic/frame_overwrite_latch.sv
`timescale 1ns/1ps
`default_nettype none

module frame_overwrite_latch (
  input  logic clk_rtx,
  input  logic sys_rst,
  input  logic obj_changed,
  input  logic cfg_changed,
  input  logic frame_end,
  input  logic force_overwrite,
  output logic overwrite
);

  // scene touched since the last frame end
  logic pending;
  logic scene_changed;

  assign scene_changed = obj_changed || cfg_changed;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      pending <= 1'b0;
      overwrite <= 1'b0;
    end else if (frame_end) begin
      // held for the whole next frame
      // a change in the frame_end cycle itself still counts
      overwrite <= force_overwrite || pending || scene_changed;
      pending <= 1'b0;
    end else if (scene_changed) begin
      pending <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/rtx_scene_pkg.sv
package rtx_scene_pkg;

  // frame start marker on the uart byte stream
  localparam logic [7:0] SYNC_BYTE = 8'hA5;

  // object table geometry
  localparam int MAX_NUM_OBJS = 16;
  localparam int OBJ_IDX_WIDTH = 4;
  // one extra bit so a full table of 16 fits
  localparam int NUM_OBJS_WIDTH = 5;

  // payload sizes of the command frames
  localparam int OBJ_BYTES = 15;
  localparam int CAM_VEC_BYTES = 9;
  localparam int FLASH_PAYLOAD_BITS = 120;
  // counts down the longest payload, 15 bytes
  localparam int BYTE_CNT_WIDTH = 4;

  // signed fixed point, 12 integer and 12 fraction bits
  typedef logic signed [23:0] fp24_t;

  localparam fp24_t FP_ONE = 24'sh001000;
  // 640.0, half of the 1280 pixel screen
  localparam fp24_t FP_HALF_SCREEN_WIDTH = 24'sh280000;

  // config register defaults
  localparam int DEFAULT_NUM_OBJS = 16;
  localparam int DEFAULT_MAX_BOUNCES = 3;

  // low three bits of a config command, bit 7 set
  localparam logic [2:0] CMD_CAM_ORIGIN = 3'd0;
  localparam logic [2:0] CMD_CAM_FORWARD = 3'd1;
  localparam logic [2:0] CMD_CAM_RIGHT = 3'd2;
  localparam logic [2:0] CMD_CAM_UP = 3'd3;
  localparam logic [2:0] CMD_NUM_OBJS = 3'd4;
  localparam logic [2:0] CMD_MAX_BOUNCES = 3'd5;

  typedef struct packed {
    fp24_t x;
    fp24_t y;
    fp24_t z;
  } vec3_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t forward;
    vec3_t right;
    vec3_t up;
  } camera_t;

  // 120 bits, same width as a flash payload
  typedef struct packed {
    vec3_t       center;
    fp24_t       radius;
    logic [15:0] color;
    logic [7:0]  material;
  } object_t;

  typedef struct packed {
    logic [7:0]                    cmd;
    logic [FLASH_PAYLOAD_BITS-1:0] payload;
    logic                          wen;
  } flash_req_t;

endpackage

//--- logic/rtx_scene_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_scene_top (
  input  logic                                    clk_rtx,
  input  logic                                    sys_rst,
  // byte stream from the uart receiver
  input  logic                                    rx_valid,
  input  logic [7:0]                              rx_byte,
  // end of the last pixel from the ray engine
  input  logic                                    frame_end,
  input  logic                                    force_overwrite,
  input  logic [rtx_scene_pkg::OBJ_IDX_WIDTH-1:0]  obj_rd_idx,
  output logic                                    flash_active,
  output rtx_scene_pkg::camera_t                  cam,
  output logic [rtx_scene_pkg::NUM_OBJS_WIDTH-1:0] num_objs,
  output logic [7:0]                              max_bounces,
  output rtx_scene_pkg::object_t                  obj,
  output logic                                    overwrite
);
  import rtx_scene_pkg::*;

  // one request feeds both scene blocks
  flash_req_t flash_req;
  logic       obj_changed;
  logic       cfg_changed;

  uart_memflash uart_memflash_i (
    .clk_rtx      (clk_rtx),
    .sys_rst      (sys_rst),
    .rx_valid     (rx_valid),
    .rx_byte      (rx_byte),
    .flash_active (flash_active),
    .flash_req    (flash_req)
  );

  // object table, read by the ray engine
  scene_buffer scene_buffer_i (
    .clk_rtx     (clk_rtx),
    .flash_req   (flash_req),
    .obj_rd_idx  (obj_rd_idx),
    .obj         (obj),
    .obj_changed (obj_changed)
  );

  // camera, object count, bounce limit
  scene_config_regs scene_config_regs_i (
    .clk_rtx     (clk_rtx),
    .sys_rst     (sys_rst),
    .flash_req   (flash_req),
    .cam         (cam),
    .num_objs    (num_objs),
    .max_bounces (max_bounces),
    .cfg_changed (cfg_changed)
  );

  // per frame overwrite flag for the frame buffer
  frame_overwrite_latch frame_overwrite_latch_i (
    .clk_rtx         (clk_rtx),
    .sys_rst         (sys_rst),
    .obj_changed     (obj_changed),
    .cfg_changed     (cfg_changed),
    .frame_end       (frame_end),
    .force_overwrite (force_overwrite),
    .overwrite       (overwrite)
  );

endmodule

`default_nettype wire

//--- logic/scene_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module scene_buffer (
  input  logic                                   clk_rtx,
  input  rtx_scene_pkg::flash_req_t              flash_req,
  input  logic [rtx_scene_pkg::OBJ_IDX_WIDTH-1:0] obj_rd_idx,
  output rtx_scene_pkg::object_t                 obj,
  output logic                                   obj_changed
);
  import rtx_scene_pkg::*;

  // one object_t per entry
  object_t mem [MAX_NUM_OBJS];

  logic                     obj_wr_en;
  logic [OBJ_IDX_WIDTH-1:0] wr_idx;

  // preload scene at startup
  initial begin
    $readmemh("logic/scene_init.mem", mem);
  end

  // object writes only, bit 7 clear and index inside the table
  assign obj_wr_en = flash_req.wen && !flash_req.cmd[7] &&
                     (flash_req.cmd[6:0] < 7'(MAX_NUM_OBJS));
  assign wr_idx = flash_req.cmd[OBJ_IDX_WIDTH-1:0];

  always_ff @(posedge clk_rtx) begin
    if (obj_wr_en) begin
      mem[wr_idx] <= object_t'(flash_req.payload);
    end
  end

  // registered read port, one cycle latency
  // a same cycle write still reads back the old entry
  always_ff @(posedge clk_rtx) begin
    obj <= mem[obj_rd_idx];
  end

  // change report for the overwrite latch, one cycle after wen
  always_ff @(posedge clk_rtx) begin
    obj_changed <= obj_wr_en;
  end

endmodule

`default_nettype wire

//--- logic/scene_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scene_config_regs (
  input  logic                                    clk_rtx,
  input  logic                                    sys_rst,
  input  rtx_scene_pkg::flash_req_t               flash_req,
  output rtx_scene_pkg::camera_t                  cam,
  output logic [rtx_scene_pkg::NUM_OBJS_WIDTH-1:0] num_objs,
  output logic [7:0]                              max_bounces,
  output logic                                    cfg_changed
);
  import rtx_scene_pkg::*;

  logic [2:0]                code;
  logic                      cfg_wr_en;
  vec3_t                     cam_vec;
  logic [NUM_OBJS_WIDTH-1:0] num_objs_clamped;

  assign code = flash_req.cmd[2:0];

  // config commands only, spare codes 6 and 7 dropped
  assign cfg_wr_en = flash_req.wen && flash_req.cmd[7] && (code <= CMD_MAX_BOUNCES);

  // camera vectors sit in the low 72 payload bits
  assign cam_vec = vec3_t'(flash_req.payload[$bits(vec3_t)-1:0]);

  // saturate the object count at the table size
  always_comb begin
    if (flash_req.payload[7:0] > 8'(MAX_NUM_OBJS)) begin
      num_objs_clamped = NUM_OBJS_WIDTH'(MAX_NUM_OBJS);
    end else begin
      num_objs_clamped = flash_req.payload[NUM_OBJS_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      // camera at origin looking down +z, screen at half width
      cam.origin <= '0;
      cam.forward <= '{x: '0, y: '0, z: FP_HALF_SCREEN_WIDTH};
      cam.right <= '{x: FP_ONE, y: '0, z: '0};
      cam.up <= '{x: '0, y: FP_ONE, z: '0};
      num_objs <= NUM_OBJS_WIDTH'(DEFAULT_NUM_OBJS);
      max_bounces <= 8'(DEFAULT_MAX_BOUNCES);
      cfg_changed <= 1'b0;
    end else begin
      // pulse in the cycle the new value shows up
      cfg_changed <= cfg_wr_en;
      if (cfg_wr_en) begin
        case (code)
          CMD_CAM_ORIGIN: begin
            cam.origin <= cam_vec;
          end
          CMD_CAM_FORWARD: begin
            cam.forward <= cam_vec;
          end
          CMD_CAM_RIGHT: begin
            cam.right <= cam_vec;
          end
          CMD_CAM_UP: begin
            cam.up <= cam_vec;
          end
          CMD_NUM_OBJS: begin
            num_objs <= num_objs_clamped;
          end
          // bounce limit taken as sent
          default: begin
            max_bounces <= flash_req.payload[7:0];
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/scene_init.mem
// center x y z, radius, rgb565 color, material; one object per line, index 0 first
00000000F80001000000100000FF50
00100000E80001100000110011EE51
00200000D80001200000120022DD52
00300000C80001300000130033CC53
00400000B80001400000140044BB54
00500000A80001500000150055AA55
006000009800016000001600669956
007000008800017000001700778857
008000007800018000001800887758
009000006800019000001900996659
00A00000580001A000001A00AA555A
00B00000480001B000001B00BB445B
00C00000380001C000001C00CC335C
00D00000280001D000001D00DD225D
00E00000180001E000001E00EE115E
00F00000080001F000001F00FF005F

//--- logic/uart_memflash.sv
`timescale 1ns/1ps
`default_nettype none

module uart_memflash (
  input  logic                      clk_rtx,
  input  logic                      sys_rst,
  input  logic                      rx_valid,
  input  logic [7:0]                rx_byte,
  output logic                      flash_active,
  output rtx_scene_pkg::flash_req_t flash_req
);
  import rtx_scene_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,
    ST_PAYLOAD
  } state_t;

  state_t                        state;
  // payload bytes still to come
  logic [BYTE_CNT_WIDTH-1:0]     byte_cnt;
  logic [7:0]                    cmd_q;
  logic [FLASH_PAYLOAD_BITS-1:0] payload_q;
  logic                          wen_q;

  // length decode of the byte arriving in ST_CMD
  logic [BYTE_CNT_WIDTH-1:0]     cmd_len;
  // codes 6 and 7 carry a throwaway byte
  logic                          cmd_is_discard;
  logic                          last_byte;

  always_comb begin
    if (!rx_byte[7]) begin
      // object write, full object_t
      cmd_len = BYTE_CNT_WIDTH'(OBJ_BYTES);
    end else begin
      case (rx_byte[2:0])
        CMD_CAM_ORIGIN,
        CMD_CAM_FORWARD,
        CMD_CAM_RIGHT,
        CMD_CAM_UP: begin
          cmd_len = BYTE_CNT_WIDTH'(CAM_VEC_BYTES);
        end
        // count, bounces and the two spare codes
        default: begin
          cmd_len = BYTE_CNT_WIDTH'(1);
        end
      endcase
    end
  end

  assign cmd_is_discard = cmd_q[7] && (cmd_q[2:1] == 2'b11);
  assign last_byte = rx_valid && (byte_cnt == BYTE_CNT_WIDTH'(1));

  // frame FSM
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state <= ST_IDLE;
      byte_cnt <= '0;
      wen_q <= 1'b0;
    end else begin
      // wen is a single cycle pulse
      wen_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          // anything but the sync byte is dropped here
          if (rx_valid && rx_byte == SYNC_BYTE) begin
            state <= ST_CMD;
          end
        end
        ST_CMD: begin
          if (rx_valid) begin
            byte_cnt <= cmd_len;
            state <= ST_PAYLOAD;
          end
        end
        ST_PAYLOAD: begin
          if (rx_valid) begin
            byte_cnt <= byte_cnt - 1'b1;
          end
          if (last_byte) begin
            // flash_active and wen change together next cycle
            state <= ST_IDLE;
            wen_q <= !cmd_is_discard;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // command latch and payload shifter, msb first
  always_ff @(posedge clk_rtx) begin
    if (rx_valid && state == ST_CMD) begin
      cmd_q <= rx_byte;
      // short payloads end up right aligned over zeros
      payload_q <= '0;
    end else if (rx_valid && state == ST_PAYLOAD) begin
      payload_q <= {payload_q[FLASH_PAYLOAD_BITS-9:0], rx_byte};
    end
  end

  // busy from the cycle after sync until the frame is done
  assign flash_active = (state != ST_IDLE);

  always_comb begin
    flash_req.cmd = cmd_q;
    flash_req.payload = payload_q;
    flash_req.wen = wen_q;
  end

endmodule

`default_nettype wire

//--- tests/rtx_scene_properties.sv
`timescale 1ns/1ps

module rtx_scene_properties (
  input logic clk_rtx,
  input logic sys_rst,
  input logic flash_active,
  input logic frame_end,
  input logic overwrite,
  // write strobe inside the top
  input logic wen
);

  // decoder idle right after reset
  property p_idle_after_reset;
    @(posedge clk_rtx) sys_rst |=> !flash_active;
  endproperty

  // overwrite only moves on a frame boundary
  property p_overwrite_on_frame_end;
    @(posedge clk_rtx) disable iff (sys_rst)
      !$stable(overwrite) |-> $past(frame_end);
  endproperty

  // one-cycle write pulse
  property p_wen_single;
    @(posedge clk_rtx) disable iff (sys_rst) wen |=> !wen;
  endproperty

  // a write always closes an active frame
  property p_wen_after_active;
    @(posedge clk_rtx) disable iff (sys_rst) wen |-> $past(flash_active);
  endproperty

  a_idle_after_reset: assert property (p_idle_after_reset)
    else $error("flash_active high in the cycle after reset");
  a_overwrite_on_frame_end: assert property (p_overwrite_on_frame_end)
    else $error("overwrite changed without a frame_end in the previous cycle");
  a_wen_single: assert property (p_wen_single)
    else $error("wen high for two consecutive cycles");
  a_wen_after_active: assert property (p_wen_after_active)
    else $error("wen high without flash_active in the previous cycle");

endmodule

bind rtx_scene_top rtx_scene_properties rtx_scene_properties_i (
  .clk_rtx      (clk_rtx),
  .sys_rst      (sys_rst),
  .flash_active (flash_active),
  .frame_end    (frame_end),
  .overwrite    (overwrite),
  .wen          (flash_req.wen)
);

//--- tests/rtx_scene_tb.sv
`timescale 1ns/1ps

module rtx_scene_tb;
  import rtx_scene_pkg::*;

  // one command of the stimulus table
  typedef struct packed {
    logic [7:0]                    cmd;
    logic [FLASH_PAYLOAD_BITS-1:0] payload;
    logic [7:0]                    len;
    logic [FLASH_PAYLOAD_BITS-1:0] expected;
    logic                          changes;
  } entry_t;

  logic                      clk_rtx;
  logic                      sys_rst;
  logic                      rx_valid;
  logic [7:0]                rx_byte;
  logic                      frame_end;
  logic                      force_overwrite;
  logic [OBJ_IDX_WIDTH-1:0]  obj_rd_idx;
  logic                      flash_active;
  camera_t                   cam;
  logic [NUM_OBJS_WIDTH-1:0] num_objs;
  logic [7:0]                max_bounces;
  object_t                   obj;
  logic                      overwrite;

  entry_t tbl[$];
  // expected scene state
  object_t                   model_mem [MAX_NUM_OBJS];
  camera_t                   model_cam;
  logic [NUM_OBJS_WIDTH-1:0] model_num_objs;
  logic [7:0]                model_bounces;
  // unsynced bytes including command lookalikes
  logic [7:0]                stray_bytes [5] = '{8'h81, 8'h03, 8'h84, 8'h10, 8'h5A};
  int                        timeout_ns = 0;

  rtx_scene_top rtx_scene_top_i (
    .clk_rtx         (clk_rtx),
    .sys_rst         (sys_rst),
    .rx_valid        (rx_valid),
    .rx_byte         (rx_byte),
    .frame_end       (frame_end),
    .force_overwrite (force_overwrite),
    .obj_rd_idx      (obj_rd_idx),
    .flash_active    (flash_active),
    .cam             (cam),
    .num_objs        (num_objs),
    .max_bounces     (max_bounces),
    .obj             (obj),
    .overwrite       (overwrite)
  );

  // 8 ns clock
  initial begin
    clk_rtx = 1'b0;
    forever #4 clk_rtx = ~clk_rtx;
  end

  // watchdog armed once the table length is known
  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("watchdog expired before the test sequence finished");
    $display("Result: FAILED");
    $fatal(1, "simulation timeout");
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("[ERROR] time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic add_entry(input logic [7:0] cmd, input logic [FLASH_PAYLOAD_BITS-1:0] payload,
                           input logic [7:0] len, input logic [FLASH_PAYLOAD_BITS-1:0] expected,
                           input logic changes);
    tbl.push_back('{cmd: cmd, payload: payload, len: len, expected: expected, changes: changes});
  endtask

  // one strobe then 0 to 4 idle cycles
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = 1 + ($urandom % 5);
    @(posedge clk_rtx);
    rx_valid <= 1'b1;
    rx_byte <= b;
    repeat (gap - 1) begin
      @(posedge clk_rtx);
      rx_valid <= 1'b0;
    end
  endtask

  // sync, command, payload msb first
  task automatic send_frame(input entry_t e);
    send_byte(SYNC_BYTE);
    send_byte(e.cmd);
    for (int i = int'(e.len) - 1; i >= 0; i--) begin
      send_byte(e.payload[i*8 +: 8]);
    end
    @(posedge clk_rtx);
    rx_valid <= 1'b0;
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    @(negedge clk_rtx);
    while (flash_active) begin
      n++;
      if (n > 50) begin
        $display("flash_active stayed high after the last payload byte");
        $display("Result: FAILED");
        $fatal(1, "decoder did not return to idle");
      end
      @(negedge clk_rtx);
    end
  endtask

  // object writes in range and config codes 0 to 5 only
  task automatic apply_model(input entry_t e);
    if (!e.cmd[7]) begin
      if (e.cmd[6:0] < 7'(MAX_NUM_OBJS)) begin
        model_mem[e.cmd[OBJ_IDX_WIDTH-1:0]] = object_t'(e.expected);
      end
    end else begin
      case (e.cmd[2:0])
        CMD_CAM_ORIGIN:  model_cam.origin = vec3_t'(e.expected[71:0]);
        CMD_CAM_FORWARD: model_cam.forward = vec3_t'(e.expected[71:0]);
        CMD_CAM_RIGHT:   model_cam.right = vec3_t'(e.expected[71:0]);
        CMD_CAM_UP:      model_cam.up = vec3_t'(e.expected[71:0]);
        CMD_NUM_OBJS:    model_num_objs = e.expected[NUM_OBJS_WIDTH-1:0];
        CMD_MAX_BOUNCES: model_bounces = e.expected[7:0];
        default: ;
      endcase
    end
  endtask

  // config outputs then all sixteen objects through the read port
  task automatic check_scene;
    @(negedge clk_rtx);
    check_value("flash_active", 128'(flash_active), 128'(1'b0));
    check_value("cam.origin", 128'(cam.origin), 128'(model_cam.origin));
    check_value("cam.forward", 128'(cam.forward), 128'(model_cam.forward));
    check_value("cam.right", 128'(cam.right), 128'(model_cam.right));
    check_value("cam.up", 128'(cam.up), 128'(model_cam.up));
    check_value("num_objs", 128'(num_objs), 128'(model_num_objs));
    check_value("max_bounces", 128'(max_bounces), 128'(model_bounces));
    for (int i = 0; i < MAX_NUM_OBJS; i++) begin
      @(posedge clk_rtx);
      obj_rd_idx <= OBJ_IDX_WIDTH'(i);
      // one cycle read latency
      @(posedge clk_rtx);
      @(negedge clk_rtx);
      check_value($sformatf("obj[%0d]", i), 128'(obj), 128'(model_mem[i]));
    end
  endtask

  task automatic pulse_frame_end(input logic force_in, input logic exp_overwrite);
    @(posedge clk_rtx);
    frame_end <= 1'b1;
    force_overwrite <= force_in;
    @(posedge clk_rtx);
    frame_end <= 1'b0;
    force_overwrite <= 1'b0;
    @(negedge clk_rtx);
    check_value("overwrite", 128'(overwrite), 128'(exp_overwrite));
  endtask

  initial begin
    int total_bytes;
    void'($urandom(89956));
    sys_rst = 1'b1;
    rx_valid = 1'b0;
    rx_byte = 8'h00;
    frame_end = 1'b0;
    force_overwrite = 1'b0;
    obj_rd_idx = '0;

    // expected state after reset
    $readmemh("logic/scene_init.mem", model_mem);
    model_cam = '0;
    model_cam.forward.z = FP_HALF_SCREEN_WIDTH;
    model_cam.right.x = FP_ONE;
    model_cam.up.y = FP_ONE;
    model_num_objs = NUM_OBJS_WIDTH'(DEFAULT_NUM_OBJS);
    model_bounces = 8'(DEFAULT_MAX_BOUNCES);

    // camera vectors
    add_entry(8'h80, 120'h00A000_FFE000_003800, 8'd9, 120'h00A000_FFE000_003800, 1'b1);
    add_entry(8'h81, 120'h000000_001800_200000, 8'd9, 120'h000000_001800_200000, 1'b1);
    add_entry(8'h82, 120'h000E00_000200_FFF400, 8'd9, 120'h000E00_000200_FFF400, 1'b1);
    add_entry(8'h83, 120'h000100_000F00_000080, 8'd9, 120'h000100_000F00_000080, 1'b1);
    // objects with the last index out of range
    add_entry(8'h03, 120'h00C000_FF8000_030000_002800_F800_07, 8'd15,
              120'h00C000_FF8000_030000_002800_F800_07, 1'b1);
    add_entry(8'h0A, 120'h123456_789ABC_DEF012_004000_07E0_21, 8'd15,
              120'h123456_789ABC_DEF012_004000_07E0_21, 1'b1);
    add_entry(8'h0F, 120'hFFF000_000800_7FF000_000100_001F_FF, 8'd15,
              120'hFFF000_000800_7FF000_000100_001F_FF, 1'b1);
    add_entry(8'h10, 120'hDEADBE_EFCAFE_BABE00_112233_4455_66, 8'd15, 120'h0, 1'b0);
    // count 9, count 40 clamps to 16, bounce limit, spare code 6
    add_entry(8'h84, 120'h09, 8'd1, 120'h09, 1'b1);
    add_entry(8'h84, 120'h28, 8'd1, 120'h10, 1'b1);
    add_entry(8'h85, 120'hC7, 8'd1, 120'hC7, 1'b1);
    add_entry(8'h86, 120'h5A, 8'd1, 120'h0, 1'b0);

    // bytes times (max gap + 1) times period times 4
    total_bytes = $size(stray_bytes);
    foreach (tbl[k]) begin
      total_bytes += int'(tbl[k].len) + 2;
    end
    timeout_ns = total_bytes * 6 * 8 * 4;

    repeat (2) @(posedge clk_rtx);
    sys_rst <= 1'b0;

    check_scene();
    check_value("overwrite", 128'(overwrite), 128'(1'b0));
    // quiet frame then forced frame then quiet again
    pulse_frame_end(1'b0, 1'b0);
    pulse_frame_end(1'b1, 1'b1);
    pulse_frame_end(1'b0, 1'b0);

    foreach (tbl[k]) begin
      send_frame(tbl[k]);
      wait_idle();
      apply_model(tbl[k]);
      repeat (2) @(posedge clk_rtx);
      check_scene();
      // flag set once and cleared by the next frame
      pulse_frame_end(1'b0, tbl[k].changes);
      pulse_frame_end(1'b0, 1'b0);
    end

    // idle decoder drops everything but sync
    foreach (stray_bytes[k]) begin
      send_byte(stray_bytes[k]);
      // decoder samples the last strobe on this edge
      @(posedge clk_rtx);
      rx_valid <= 1'b0;
      @(negedge clk_rtx);
      check_value("flash_active", 128'(flash_active), 128'(1'b0));
    end
    repeat (2) @(posedge clk_rtx);
    check_scene();
    pulse_frame_end(1'b0, 1'b0);

    $display("Result: PASSED");
    $finish;
  end

endmodule
